// File: rvDecode_cfg.svh
`ifndef RVDECODE_CFG_SVH
`define RVDECODE_CFG_SVH

// instruction FIFO entries
`define RVD_FIFO_DEPTH 4

// APB address width
`define RVD_ADDR_W 8

// register map
`define RVD_INSTR_ADDR 8'h00
`define RVD_STATUS_ADDR 8'h04

// status word layout
`define RVD_STAT_FULL_BIT 8
`define RVD_STAT_EMPTY_BIT 9

`endif

// File: rvDecodePkg.sv
`include "rvDecode_cfg.svh"

package rvDecodePkg;

    // major opcodes of the decoded groups
    typedef enum logic [6:0] {
        opR      = 7'b0110011,
        opRW     = 7'b0111011,
        opJalr   = 7'b1100111,
        opLoad   = 7'b0000011,
        opImm    = 7'b0010011,
        opImmW   = 7'b0011011,
        opStore  = 7'b0100011,
        opBranch = 7'b1100011,
        opLui    = 7'b0110111,
        opAuipc  = 7'b0010111,
        opJal    = 7'b1101111
    } rvOpcode_t;

    typedef enum logic [2:0] {
        clsR,
        clsI,
        clsS,
        clsB,
        clsU,
        clsJ,
        clsNone
    } instrClass_t;

    // ILLEGAL first so an all-zero record reads as illegal
    typedef enum logic [5:0] {
        ILLEGAL,
        ADD, SUB, MUL, SLL, MULH, SLT, MULHSU, SLTU, MULHU,
        XOR, DIV, SRL, SRA, DIVU, OR, REM, AND, REMU,
        ADDW, SUBW, MULW, SLLW, DIVW, SRLW, SRAW, DIVUW, REMW, REMUW,
        JALR,
        LB, LH, LW, LD, LBU, LHU, LWU,
        ADDI, SLLI, SLTI, SLTIU, XORI, SRLI, SRAI, ORI, ANDI,
        ADDIW, SLLIW, SRLIW, SRAIW,
        SB, SH, SW, SD,
        BEQ, BNE, BLT, BGE, BLTU, BGEU,
        LUI, AUIPC, JAL
    } rvOp_t;

    typedef struct packed {
        logic                   psel;
        logic                   penable;
        logic                   pwrite;
        logic [`RVD_ADDR_W-1:0] paddr;
        logic [31:0]            pwdata;
    } apbReq_t;

    typedef struct packed {
        logic        pready;
        logic [31:0] prdata;
        logic        pslverr;
    } apbRsp_t;

    typedef struct packed {
        instrClass_t cls;
        rvOp_t       op;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [31:0] imm;
        logic        illegal;
    } decoded_t;

endpackage

// File: apbInstrPort.sv
`timescale 1ns/1ps
`include "rvDecode_cfg.svh"

module apbInstrPort (
    input  logic                 clk,
    input  logic                 rstN,
    input  rvDecodePkg::apbReq_t req,
    output rvDecodePkg::apbRsp_t rsp,
    input  logic                 full,
    input  logic                 empty,
    input  logic [3:0]           level,
    output logic                 push,
    output logic [31:0]          pushData
);

    logic        setup;
    logic        access;
    logic        instrWrite;
    logic        statusRead;
    logic        setupSeen;
    logic [31:0] statusWord;
    logic [31:0] statusQ;

    assign setup  = req.psel && !req.penable;
    assign access = req.psel && req.penable;

    // address and direction decode
    assign instrWrite = req.pwrite && (req.paddr == `RVD_INSTR_ADDR);
    assign statusRead = !req.pwrite && (req.paddr == `RVD_STATUS_ADDR);

    always_comb begin
        statusWord = 32'd0;
        statusWord[3:0] = level;
        statusWord[`RVD_STAT_FULL_BIT] = full;
        statusWord[`RVD_STAT_EMPTY_BIT] = empty;
    end

    // tracks that the current access phase followed a setup phase
    always_ff @(posedge clk) begin
        if (!rstN) begin
            setupSeen <= 1'b0;
        end else if (setup) begin
            setupSeen <= 1'b1;
        end else if (access && rsp.pready) begin
            setupSeen <= 1'b0;
        end
    end

    // status sampled in the setup phase and returned in the access phase
    always_ff @(posedge clk) begin
        if (setup) begin
            statusQ <= statusWord;
        end
    end

    // wait states only for instruction writes into a full FIFO
    assign rsp.pready  = !(access && instrWrite && full);
    assign rsp.pslverr = access && !instrWrite && !statusRead;
    assign rsp.prdata  = (access && statusRead) ? statusQ : 32'd0;

    assign push     = access && setupSeen && instrWrite && !full;
    assign pushData = req.pwdata;

endmodule

// File: instrFifo.sv
`timescale 1ns/1ps

module instrFifo #(
    parameter int DEPTH = 4
) (
    input  logic        clk,
    input  logic        rstN,
    input  logic        push,
    input  logic [31:0] pushData,
    input  logic        pop,
    output logic [31:0] head,
    output logic        notEmpty,
    output logic        full,
    output logic [3:0]  level
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [31:0]   mem [DEPTH];
    logic [AW-1:0] wrPtr;
    logic [AW-1:0] rdPtr;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wrPtr] <= pushData;
        end
    end

    // pointers wrap at DEPTH, which need not be a power of two
    always_ff @(posedge clk) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            level <= 4'd0;
        end else begin
            if (push) begin
                wrPtr <= (wrPtr == AW'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= (rdPtr == AW'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
            end
            if (push && !pop) begin
                level <= level + 4'd1;
            end else if (pop && !push) begin
                level <= level - 4'd1;
            end
        end
    end

    assign head     = mem[rdPtr];
    assign notEmpty = (level != 4'd0);
    assign full     = (level == 4'(DEPTH));

endmodule

// File: instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic [31:0]           instr,
    input  logic                  notEmpty,
    output logic                  pop,
    output logic                  decValid,
    output rvDecodePkg::decoded_t dec,
    input  logic                  decReady
);

    import rvDecodePkg::*;

    rvOpcode_t   opcode;
    rvOp_t       op;
    instrClass_t cls;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic        isShift;
    logic        isWord;
    logic [5:0]  shamt;
    decoded_t    decNext;

    assign opcode = rvOpcode_t'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // operation select
    always_comb begin
        op = ILLEGAL;
        cls = clsNone;
        isShift = 1'b0;
        isWord = 1'b0;
        case (opcode)
            opR: begin
                cls = clsR;
                case ({funct7, funct3})
                    10'b0000000_000: op = ADD;
                    10'b0100000_000: op = SUB;
                    10'b0000001_000: op = MUL;
                    10'b0000000_001: op = SLL;
                    10'b0000001_001: op = MULH;
                    10'b0000000_010: op = SLT;
                    10'b0000001_010: op = MULHSU;
                    10'b0000000_011: op = SLTU;
                    10'b0000001_011: op = MULHU;
                    10'b0000000_100: op = XOR;
                    10'b0000001_100: op = DIV;
                    10'b0000000_101: op = SRL;
                    10'b0100000_101: op = SRA;
                    10'b0000001_101: op = DIVU;
                    10'b0000000_110: op = OR;
                    10'b0000001_110: op = REM;
                    10'b0000000_111: op = AND;
                    10'b0000001_111: op = REMU;
                    default: op = ILLEGAL;
                endcase
            end
            opRW: begin
                cls = clsR;
                case ({funct7, funct3})
                    10'b0000000_000: op = ADDW;
                    10'b0100000_000: op = SUBW;
                    10'b0000001_000: op = MULW;
                    10'b0000000_001: op = SLLW;
                    10'b0000001_100: op = DIVW;
                    10'b0000000_101: op = SRLW;
                    10'b0100000_101: op = SRAW;
                    10'b0000001_101: op = DIVUW;
                    10'b0000001_110: op = REMW;
                    10'b0000001_111: op = REMUW;
                    default: op = ILLEGAL;
                endcase
            end
            opJalr: begin
                cls = clsI;
                op = (funct3 == 3'b000) ? JALR : ILLEGAL;
            end
            opLoad: begin
                cls = clsI;
                case (funct3)
                    3'b000: op = LB;
                    3'b001: op = LH;
                    3'b010: op = LW;
                    3'b011: op = LD;
                    3'b100: op = LBU;
                    3'b101: op = LHU;
                    3'b110: op = LWU;
                    default: op = ILLEGAL;
                endcase
            end
            opImm: begin
                cls = clsI;
                isShift = (funct3 == 3'b001) || (funct3 == 3'b101);
                case (funct3)
                    3'b000: op = ADDI;
                    3'b001: op = (instr[31:26] == 6'd0) ? SLLI : ILLEGAL;
                    3'b010: op = SLTI;
                    3'b011: op = SLTIU;
                    3'b100: op = XORI;
                    // bit 30 picks arithmetic and bit 25 belongs to shamt
                    3'b101: begin
                        if (!instr[31] && instr[29:26] == 4'd0) begin
                            op = instr[30] ? SRAI : SRLI;
                        end
                    end
                    3'b110: op = ORI;
                    default: op = ANDI;
                endcase
            end
            opImmW: begin
                cls = clsI;
                isWord = 1'b1;
                isShift = (funct3 == 3'b001) || (funct3 == 3'b101);
                case (funct3)
                    3'b000: op = ADDIW;
                    3'b001: op = (funct7 == 7'd0) ? SLLIW : ILLEGAL;
                    3'b101: begin
                        if (funct7 == 7'b0000000 || funct7 == 7'b0100000) begin
                            op = instr[30] ? SRAIW : SRLIW;
                        end
                    end
                    default: op = ILLEGAL;
                endcase
            end
            opStore: begin
                cls = clsS;
                case (funct3)
                    3'b000: op = SB;
                    3'b001: op = SH;
                    3'b010: op = SW;
                    3'b011: op = SD;
                    default: op = ILLEGAL;
                endcase
            end
            opBranch: begin
                cls = clsB;
                case (funct3)
                    3'b000: op = BEQ;
                    3'b001: op = BNE;
                    3'b100: op = BLT;
                    3'b101: op = BGE;
                    3'b110: op = BLTU;
                    3'b111: op = BGEU;
                    default: op = ILLEGAL;
                endcase
            end
            opLui: begin
                cls = clsU;
                op = LUI;
            end
            opAuipc: begin
                cls = clsU;
                op = AUIPC;
            end
            opJal: begin
                cls = clsJ;
                op = JAL;
            end
            default: op = ILLEGAL;
        endcase
    end

    // word shifts take 5 bits of shamt
    assign shamt = isWord ? {1'b0, instr[24:20]} : instr[25:20];

    // field and immediate assembly
    always_comb begin
        decNext = '0;
        decNext.op = op;
        decNext.cls = cls;
        if (op == ILLEGAL) begin
            decNext.cls = clsNone;
            decNext.illegal = 1'b1;
        end else begin
            if (cls != clsS && cls != clsB) begin
                decNext.rd = instr[11:7];
            end
            if (cls != clsU && cls != clsJ) begin
                decNext.rs1 = instr[19:15];
            end
            if (cls == clsR || cls == clsS || cls == clsB) begin
                decNext.rs2 = instr[24:20];
            end
            case (cls)
                clsI: begin
                    decNext.imm = isShift ? {26'd0, shamt} : {{20{instr[31]}}, instr[31:20]};
                end
                clsS: decNext.imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                clsB: begin
                    decNext.imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                                   instr[11:8], 1'b0};
                end
                clsU: decNext.imm = {instr[31:12], 12'd0};
                clsJ: begin
                    decNext.imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                                   instr[30:21], 1'b0};
                end
                default: decNext.imm = 32'd0;
            endcase
        end
    end

    // take a word when the output slot is free or draining
    assign pop = notEmpty && (!decValid || decReady);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            decValid <= 1'b0;
        end else if (pop) begin
            decValid <= 1'b1;
        end else if (decReady) begin
            decValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            dec <= decNext;
        end
    end

endmodule

// File: rvDecodeTop.sv
`timescale 1ns/1ps
`include "rvDecode_cfg.svh"

module rvDecodeTop (
    input  logic                  clk,
    input  logic                  rstN,
    input  rvDecodePkg::apbReq_t  apbReq,
    output rvDecodePkg::apbRsp_t  apbRsp,
    output logic                  decValid,
    output rvDecodePkg::decoded_t dec,
    input  logic                  decReady
);

    logic        push;
    logic [31:0] pushData;
    logic        pop;
    logic [31:0] head;
    logic        notEmpty;
    logic        full;
    logic [3:0]  level;

    apbInstrPort uPort (
        .clk      (clk),
        .rstN     (rstN),
        .req      (apbReq),
        .rsp      (apbRsp),
        .full     (full),
        .empty    (!notEmpty),
        .level    (level),
        .push     (push),
        .pushData (pushData)
    );

    instrFifo #(
        .DEPTH (`RVD_FIFO_DEPTH)
    ) uFifo (
        .clk      (clk),
        .rstN     (rstN),
        .push     (push),
        .pushData (pushData),
        .pop      (pop),
        .head     (head),
        .notEmpty (notEmpty),
        .full     (full),
        .level    (level)
    );

    instrDecoder uDecoder (
        .clk      (clk),
        .rstN     (rstN),
        .instr    (head),
        .notEmpty (notEmpty),
        .pop      (pop),
        .decValid (decValid),
        .dec      (dec),
        .decReady (decReady)
    );

endmodule

// File: rvDecode_properties.sv
`timescale 1ns/1ps
`include "rvDecode_cfg.svh"

module rvDecodeProps (
    input logic                  clk,
    input logic                  rstN,
    input rvDecodePkg::apbReq_t  apbReq,
    input rvDecodePkg::apbRsp_t  apbRsp,
    input logic                  decValid,
    input rvDecodePkg::decoded_t dec,
    input logic                  decReady
);

    // a stalled record stays put
    recordHeld: assert property (@(posedge clk) disable iff (!rstN)
        decValid && !decReady |=> decValid && $stable(dec))
        else $error("record changed while stalled");

    errWithReady: assert property (@(posedge clk)
        apbRsp.pslverr |-> apbRsp.pready)
        else $error("pslverr without pready");

    noValidInReset: assert property (@(posedge clk)
        !rstN |=> !decValid)
        else $error("decValid high during reset");

    // status reads never wait
    statusNoWait: assert property (@(posedge clk) disable iff (!rstN)
        apbReq.psel && apbReq.penable && !apbReq.pwrite
            && apbReq.paddr == `RVD_STATUS_ADDR |-> apbRsp.pready)
        else $error("wait state on status read");

endmodule

bind rvDecodeTop rvDecodeProps propsI (.*);

// File: rvDecodeTb.sv
`timescale 1ns/1ps
`include "rvDecode_cfg.svh"

module rvDecodeTb;

    import rvDecodePkg::*;

    localparam int FIELDS = 9;
    localparam int MAX_LINES = 64;

    logic     clk;
    logic     rstN;
    apbReq_t  apbReq;
    apbRsp_t  apbRsp;
    logic     decValid;
    decoded_t dec;
    logic     decReady;

    logic [31:0] testMem [FIELDS*MAX_LINES];
    decoded_t    expQ [$];
    int          numLines;
    int          cycleCount;
    int          timeoutLimit;
    logic        holdReady;
    logic [31:0] lcgState;

    rvDecodeTop dut_i (
        .clk      (clk),
        .rstN     (rstN),
        .apbReq   (apbReq),
        .apbRsp   (apbRsp),
        .decValid (decValid),
        .dec      (dec),
        .decReady (decReady)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic stopWithFail(input string reason);
        if (reason.len() > 0) begin
            $display("ERROR at %0t: %s", $time, reason);
        end
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            $display("MISMATCH time=%0t signal=%s expected=%0h actual=%0h",
                     $time, name, exp, act);
            stopWithFail("");
        end
    endtask

    // consumer stalls about a third of the time
    always @(posedge clk) begin
        if (!rstN || holdReady) begin
            decReady <= 1'b0;
        end else begin
            lcgState <= lcgNext(lcgState);
            decReady <= (lcgState[31:16] % 3) != 0;
        end
    end

    // records must leave the output in write order
    always @(posedge clk) begin : monitor
        decoded_t expRec;
        if (rstN && decValid && decReady) begin
            if (expQ.size() == 0) begin
                stopWithFail("decoder produced a record that was never written");
            end else begin
                expRec = expQ.pop_front();
                compare("dec.op", 64'(expRec.op), 64'(dec.op));
                compare("dec.cls", 64'(expRec.cls), 64'(dec.cls));
                compare("dec.rd", 64'(expRec.rd), 64'(dec.rd));
                compare("dec.rs1", 64'(expRec.rs1), 64'(dec.rs1));
                compare("dec.rs2", 64'(expRec.rs2), 64'(dec.rs2));
                compare("dec.imm", 64'(expRec.imm), 64'(dec.imm));
                compare("dec.illegal", 64'(expRec.illegal), 64'(dec.illegal));
            end
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (timeoutLimit > 0 && cycleCount >= timeoutLimit) begin
            stopWithFail("timeout, the tests did not finish in the cycle limit");
        end
    end

    // runs one APB transfer and releases the consumer after releaseAt wait states
    task automatic apbXfer(input logic write, input logic [7:0] addr, input logic [31:0] data,
                           input int releaseAt, output logic [31:0] rdata,
                           output logic slverr, output int waits);
        waits = 0;
        @(posedge clk);
        apbReq.psel    <= 1'b1;
        apbReq.penable <= 1'b0;
        apbReq.pwrite  <= write;
        apbReq.paddr   <= addr;
        apbReq.pwdata  <= data;
        @(posedge clk);
        apbReq.penable <= 1'b1;
        @(posedge clk);
        while (!apbRsp.pready) begin
            waits++;
            if (releaseAt > 0 && waits == releaseAt) begin
                holdReady <= 1'b0;
            end
            @(posedge clk);
        end
        rdata = apbRsp.prdata;
        slverr = apbRsp.pslverr;
        apbReq <= '0;
    endtask

    task automatic runLine(input int idx);
        logic [31:0] f [FIELDS];
        decoded_t    e;
        logic [31:0] rdata;
        logic        slverr;
        int          waits;
        for (int k = 0; k < FIELDS; k++) begin
            f[k] = testMem[idx*FIELDS + k];
        end
        e.op = rvOp_t'(f[2][5:0]);
        e.cls = instrClass_t'(f[3][2:0]);
        e.rd = f[4][4:0];
        e.rs1 = f[5][4:0];
        e.rs2 = f[6][4:0];
        e.imm = f[7];
        e.illegal = f[8][0];
        case (f[0])
            32'd1: begin
                expQ.push_back(e);
                apbXfer(1'b1, `RVD_INSTR_ADDR, f[1], 0, rdata, slverr, waits);
                compare("pslverr", 64'd0, 64'(slverr));
            end
            32'd2: begin
                // with the consumer held, the first record must already sit in the decoder
                if (holdReady) begin
                    while (!decValid) begin
                        @(posedge clk);
                    end
                end
                apbXfer(1'b0, f[1][7:0], 32'd0, 0, rdata, slverr, waits);
                compare("prdata", 64'(f[7]), 64'(rdata));
                compare("pslverr", 64'd0, 64'(slverr));
                compare("status wait states", 64'd0, 64'(waits));
            end
            32'd3: begin
                apbXfer(f[2][0], f[1][7:0], 32'h0000_0013, 0, rdata, slverr, waits);
                compare("pslverr", 64'd1, 64'(slverr));
            end
            32'd4: begin
                while (expQ.size() > 0) begin
                    @(posedge clk);
                end
                @(posedge clk);
                compare("decValid", 64'd0, 64'(decValid));
            end
            32'd5: begin
                holdReady <= 1'b1;
            end
            32'd6: begin
                expQ.push_back(e);
                apbXfer(1'b1, `RVD_INSTR_ADDR, f[1], 4, rdata, slverr, waits);
                compare("write stalled while full", 64'd1, 64'(waits >= 4));
                compare("pslverr", 64'd0, 64'(slverr));
            end
            default: stopWithFail($sformatf("unknown command %0h in test line %0d", f[0], idx));
        endcase
    endtask

    initial begin
        clk = 1'b0;
        rstN = 1'b0;
        apbReq = '0;
        decReady = 1'b0;
        holdReady = 1'b0;
        lcgState = 32'h0e4a_082d;
        cycleCount = 0;
        timeoutLimit = 0;
        numLines = 0;
        for (int i = 0; i < FIELDS*MAX_LINES; i++) begin
            testMem[i] = 32'd0;
        end
        $readmemh("rvDecode_tests.txt", testMem);
        while (numLines < MAX_LINES && testMem[numLines*FIELDS] != 32'd0) begin
            numLines++;
        end
        if (numLines == 0) begin
            stopWithFail("no tests were read from rvDecode_tests.txt");
        end
        timeoutLimit = 20 * numLines + 200;

        repeat (16) @(posedge clk);
        rstN <= 1'b1;
        @(posedge clk);
        compare("pready", 64'd1, 64'(apbRsp.pready));
        compare("pslverr", 64'd0, 64'(apbRsp.pslverr));
        compare("decValid", 64'd0, 64'(decValid));

        for (int i = 0; i < numLines; i++) begin
            runLine(i);
        end

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// File: rvDecode_tests.txt
// cmd: 1 write, 2 status read, 3 access expecting pslverr, 4 drain, 5 hold decReady, 6 stalled write
// cmd word op cls rd rs1 rs2 imm illegal (hex); cmd 2 has prdata in imm, cmd 3 has pwrite in op
1 003100B3 01 0 01 02 03 00000000 0
1 407302B3 02 0 05 06 07 00000000 0
1 02C5A533 07 0 0a 0b 0c 00000000 0
1 41DF5FB3 0d 0 1f 1e 1d 00000000 0
1 02947233 12 0 04 08 09 00000000 0
3 00000008 1 0 00 00 00 00000000 0
3 00000000 0 0 00 00 00 00000000 0
1 403100BB 14 0 01 02 03 00000000 0
1 0283D33B 1a 0 06 07 08 00000000 0
1 FFC280E7 1d 1 01 05 00 FFFFFFFC 0
1 01013503 21 1 0a 02 00 00000010 0
1 7FF26183 24 1 03 04 00 000007FF 0
1 FFF00093 25 1 01 00 00 FFFFFFFF 0
1 03F19113 26 1 02 03 00 0000003F 0
1 02135293 2a 1 05 06 00 00000021 0
1 40545393 2b 1 07 08 00 00000005 0
1 00153493 28 1 09 0a 00 00000001 0
1 8002821B 2e 1 04 05 00 FFFFF800 0
1 41F3D31B 31 1 06 07 00 0000001F 0
1 FE513C23 35 2 00 02 05 FFFFFFF8 0
1 001182A3 32 2 00 03 01 00000005 0
1 00208863 36 3 00 01 02 00000010 0
1 FE41FEE3 3b 3 00 03 04 FFFFFFFC 0
1 123452B7 3c 4 05 00 00 12345000 0
1 FFFFF397 3d 4 07 00 00 FFFFF000 0
1 001000EF 3e 5 01 00 00 00000800 0
1 FFFFF06F 3e 5 00 00 00 FFFFFFFE 0
1 403110B3 00 6 00 00 00 00000000 1
1 0000000F 00 6 00 00 00 00000000 1
1 00000073 00 6 00 00 00 00000000 1
1 00002063 00 6 00 00 00 00000000 1
1 00004501 00 6 00 00 00 00000000 1
1 0210911B 00 6 00 00 00 00000000 1
3 00000004 1 0 00 00 00 00000000 0
4 00000000 0 0 00 00 00 00000000 0
2 00000004 0 0 00 00 00 00000200 0
5 00000000 0 0 00 00 00 00000000 0
1 003100B3 01 0 01 02 03 00000000 0
1 FFF00093 25 1 01 00 00 FFFFFFFF 0
1 FE513C23 35 2 00 02 05 FFFFFFF8 0
1 00208863 36 3 00 01 02 00000010 0
1 123452B7 3c 4 05 00 00 12345000 0
2 00000004 0 0 00 00 00 00000104 0
6 001000EF 3e 5 01 00 00 00000800 0
4 00000000 0 0 00 00 00 00000000 0
2 00000004 0 0 00 00 00 00000200 0
0 00000000 0 0 00 00 00 00000000 0

// File: list.f
+incdir+.
rvDecodePkg.sv
apbInstrPort.sv
instrFifo.sv
instrDecoder.sv
rvDecodeTop.sv
rvDecode_properties.sv
rvDecodeTb.sv

// File: Makefile
TOP    ?= rvDecodeTb
SEED   ?= 0
VFLAGS ?= --binary --timing --assert -j 0

OBJ_DIR := obj_dir

.PHONY: sim clean

sim:
	verilator $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f list.f
	./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED) | tee /dev/stderr | \
		grep -q "Simulation finished: PASS"

clean:
	rm -rf $(OBJ_DIR)
